// ==== Makefile ====
# Verilator flow for the microcoded CPU and its testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= Done: no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Pass only when the log holds the pass line
sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
source/cpu_pkg.sv
source/ctrl_if.sv
source/alu.sv
source/ucode_decoder.sv
source/sequencer.sv
source/datapath.sv
source/ram.sv
source/cpu_top.sv
test/tb_cpu.sv

// ==== source/alu.sv ====
////////////////////////////////////////
// Six-control-bit ALU with C, Z, GT, LT
// condition flags
////////////////////////////////////////
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::word_t  x,
    input  cpu_pkg::word_t  y,
    input  logic [5:0]      alu_ctl,     // EX NX EY NY F NO
    output cpu_pkg::word_t  result,
    output cpu_pkg::flags_t flags
);
    import cpu_pkg::*;

    logic ex, nx, ey, ny, fn, no;
    word_t xg, yg;                       // Operands after enable and invert
    word_t raw;
    logic [WORD_W:0] sum;                // Extra bit is the carry

    assign {ex, nx, ey, ny, fn, no} = alu_ctl;

    always_comb begin
        xg = ex ? x : '0;
        if (nx) begin
            xg = ~xg;
        end
        yg = ey ? y : '0;
        if (ny) begin
            yg = ~yg;
        end
    end

    assign sum    = {1'b0, xg} + {1'b0, yg};
    assign raw    = fn ? sum[WORD_W-1:0] : (xg & yg);
    assign result = no ? ~raw : raw;

    // Flags from the final result, carry only on add
    assign flags.c  = fn & sum[WORD_W];
    assign flags.z  = (result == '0);
    assign flags.lt = result[WORD_W-1];
    assign flags.gt = ~flags.z & ~flags.lt;

endmodule

// ==== source/cpu_pkg.sv ====
////////////////////////////////////////
// Shared types and codes for the micro-
// coded accumulator CPU, imported by all
////////////////////////////////////////

package cpu_pkg;

    localparam int WORD_W = 16;                 // Bus and register width

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [15:0]       uinstr_t;        // Microinstruction, see decoder for layout

    // Instruction opcode, bits 15..12 of an instruction word
    typedef enum logic [3:0] {
        OP_NOP = 4'h0,
        OP_LDX = 4'h1,
        OP_LDY = 4'h2,
        OP_ADD = 4'h3,
        OP_SUB = 4'h4,
        OP_AND = 4'h5,
        OP_OR  = 4'h6,
        OP_OUT = 4'h7,
        OP_JMP = 4'h8,
        OP_JZ  = 4'h9,
        OP_JC  = 4'ha,
        OP_JLT = 4'hb,
        OP_HLT = 4'hc
    } opcode_e;

    typedef enum logic [2:0] {
        SRC_PO, SRC_IOH, SRC_IOL, SRC_RO, SRC_XO, SRC_YO, SRC_DO, SRC_SPARE
    } bus_src_e;

    typedef enum logic [2:0] {
        DST_NONE, DST_MI, DST_II, DST_RI, DST_XI, DST_YI, DST_DI, DST_HALT
    } bus_dst_e;

    typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_HALTED} seq_state_e;

    typedef struct packed {
        logic c;                                // Carry out of the adder
        logic z;                                // Zero result
        logic gt;                               // Positive, nonzero
        logic lt;                               // Negative as signed
    } flags_t;

    // ALU field {EX, NX, EY, NY, F, NO}
    localparam logic [5:0] ALU_ADD = 6'b101010;
    localparam logic [5:0] ALU_SUB = 6'b111011; // ~(~x + y) = x - y
    localparam logic [5:0] ALU_AND = 6'b101000;
    localparam logic [5:0] ALU_OR  = 6'b111101; // ~(~x & ~y)

endpackage

// ==== source/cpu_top.sv ====
////////////////////////////////////////
// CPU top level: sequencer, decoder,
// datapath and program RAM
////////////////////////////////////////
`timescale 1ns/1ps

module cpu_top #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              load_en,   // RAM write, ignored while running
    input  logic [ADDR_W-1:0] load_addr,
    input  cpu_pkg::word_t    load_data,
    input  logic              run,       // One-cycle pulse
    output cpu_pkg::word_t    out_data,
    output logic              out_valid,
    output logic              halted
);
    import cpu_pkg::*;

    ctrl_if ctl ();

    uinstr_t           uinstr;
    opcode_e           ir_op;
    logic              active;
    logic              idle;
    logic [ADDR_W-1:0] mar;
    word_t             ram_data;

    assign idle      = halted | ~active;
    assign out_valid = ctl.dev_out;      // Single T2 cycle of OUT

    sequencer seq_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .run    (run),
        .ir_op  (ir_op),
        .uinstr (uinstr),
        .active (active),
        .halted (halted),
        .ctl    (ctl.seq)
    );

    ucode_decoder dec_i (
        .uinstr (uinstr),
        .active (active),
        .ctl    (ctl.dec)
    );

    datapath #(.ADDR_W(ADDR_W)) dp_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .run      (run),
        .ctl      (ctl.dp),
        .ram_data (ram_data),
        .mar      (mar),
        .ir_op    (ir_op),
        .out_data (out_data)
    );

    ram #(.ADDR_W(ADDR_W)) ram_i (
        .clk       (clk),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .idle      (idle),
        .mar       (mar),
        .ram_data  (ram_data),
        .ctl       (ctl.mem)
    );

endmodule

// ==== source/ctrl_if.sv ====
////////////////////////////////////////
// Decoded control strobes from the
// microcode decoder to their users
////////////////////////////////////////
`timescale 1ns/1ps

interface ctrl_if;

    // Bus sources, one at a time
    logic alu_out, pc_out, irh_out, irl_out, ram_out, x_out, y_out, dev_out;
    // Bus destinations
    logic mar_in, ir_in, ram_in, x_in, y_in, dev_in, halt;
    logic       rt;                 // Reset T-state
    logic       pc_inc;             // P+
    logic [5:0] alu_ctl;            // EX NX EY NY F NO
    logic       jc, jz, jgt, jlt;   // Jump enables

    modport dec (
        output alu_out, pc_out, irh_out, irl_out, ram_out, x_out, y_out, dev_out,
        output mar_in, ir_in, ram_in, x_in, y_in, dev_in, halt,
        output rt, pc_inc, alu_ctl, jc, jz, jgt, jlt
    );

    modport dp (
        input alu_out, pc_out, irh_out, irl_out, ram_out, x_out, y_out, dev_out,
        input mar_in, ir_in, x_in, y_in, dev_in,
        input pc_inc, alu_ctl, jc, jz, jgt, jlt
    );

    modport mem (input ram_out, ram_in);

    modport seq (input rt, halt);

endinterface

// ==== source/datapath.sv ====
////////////////////////////////////////
// PC, IR, MAR, X, Y and flags around a
// shared bus, with jump evaluation
////////////////////////////////////////
`timescale 1ns/1ps

module datapath #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run,
    ctrl_if.dp                ctl,
    input  cpu_pkg::word_t    ram_data,  // Already gated by RO
    output logic [ADDR_W-1:0] mar,
    output cpu_pkg::opcode_e  ir_op,
    output cpu_pkg::word_t    out_data
);
    import cpu_pkg::*;

    word_t             bus;
    word_t             x, y, ir;
    word_t             alu_result;
    flags_t            alu_flags;
    flags_t            flags;            // Stored condition flags
    logic [ADDR_W-1:0] pc;
    logic              jump;

    alu alu_i (
        .x       (x),
        .y       (y),
        .alu_ctl (ctl.alu_ctl),
        .result  (alu_result),
        .flags   (alu_flags)
    );

    // Wired-OR bus, decoder keeps sources one-hot
    assign bus = ({WORD_W{ctl.alu_out}} & alu_result)
               | ({WORD_W{ctl.pc_out}}  & WORD_W'(pc))
               | ({WORD_W{ctl.irh_out}} & {8'h00, ir[15:8]})
               | ({WORD_W{ctl.irl_out}} & {8'h00, ir[7:0]})  // Zero-extended operand
               | ram_data
               | ({WORD_W{ctl.x_out}}   & x)
               | ({WORD_W{ctl.y_out}}   & y);

    // Any matching enable, or all four for JMP
    assign jump = (ctl.jc & flags.c) | (ctl.jz & flags.z)
                | (ctl.jgt & flags.gt) | (ctl.jlt & flags.lt)
                | (ctl.jc & ctl.jz & ctl.jgt & ctl.jlt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= '0;
            x     <= '0;
            y     <= '0;
            flags <= '0;
        end else begin
            if (run) begin
                pc <= '0;
            end else if (jump) begin
                pc <= bus[ADDR_W-1:0];
            end else if (ctl.pc_inc) begin
                pc <= pc + 1'b1;
            end
            if (ctl.x_in) x <= bus;
            if (ctl.y_in) y <= bus;
            if (ctl.alu_out) flags <= alu_flags;  // Only on ALU cycles
        end
    end

    always_ff @(posedge clk) begin
        if (ctl.mar_in) mar <= bus[ADDR_W-1:0];
        if (ctl.ir_in)  ir  <= bus;
    end

    assign ir_op    = opcode_e'(ir[15:12]);
    assign out_data = x;                 // Device port shows X

endmodule

// ==== source/ram.sv ====
////////////////////////////////////////
// Program memory, loaded from outside
// while idle, read onto the bus
////////////////////////////////////////
`timescale 1ns/1ps

module ram #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              load_en,
    input  logic [ADDR_W-1:0] load_addr,
    input  cpu_pkg::word_t    load_data,
    input  logic              idle,      // Machine not running
    input  logic [ADDR_W-1:0] mar,
    output cpu_pkg::word_t    ram_data,
    ctrl_if.mem               ctl
);
    import cpu_pkg::*;

    word_t mem [2**ADDR_W];
    logic  we;

    // Load port locked out while running or while RI is up
    assign we = load_en & idle & ~ctl.ram_in;

    always_ff @(posedge clk) begin
        if (we) begin
            mem[load_addr] <= load_data;
        end
    end

    // Combinational read, drives only when selected
    assign ram_data = ctl.ram_out ? mem[mar] : '0;

endmodule

// ==== source/sequencer.sv ====
////////////////////////////////////////
// Run control, T-state counter and the
// microcode table indexed by opcode
////////////////////////////////////////
`timescale 1ns/1ps

module sequencer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run,       // One-cycle start pulse
    input  cpu_pkg::opcode_e  ir_op,
    output cpu_pkg::uinstr_t  uinstr,
    output logic              active,
    output logic              halted,
    ctrl_if.seq               ctl
);
    import cpu_pkg::*;

    seq_state_e state;
    logic [1:0] t_state;

    // Non-ALU microword
    function automatic uinstr_t mw_bus(bus_src_e src, bus_dst_e dst, logic rt,
                                       logic pinc, logic [3:0] jmp);
        return {1'b1, src, rt, pinc, 1'b0, dst, jmp, 2'b00};
    endfunction

    // ALU drives the bus, no RT bit available
    function automatic uinstr_t mw_alu(logic [5:0] op, bus_dst_e dst);
        return {1'b0, op, dst, 4'b0000, 2'b00};
    endfunction

    assign active = (state == ST_RUN);
    assign halted = (state == ST_HALTED);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            t_state <= 2'd0;
        end else if (run) begin                  // Restart from any state
            state   <= ST_RUN;
            t_state <= 2'd0;
        end else if (state == ST_RUN) begin
            if (ctl.halt) begin
                state <= ST_HALTED;
            end
            // ALU words can't carry RT, so T2 wraps too
            if (ctl.rt || t_state == 2'd2) begin
                t_state <= 2'd0;
            end else begin
                t_state <= t_state + 2'd1;
            end
        end
    end

    // Microcode table
    always_comb begin
        uinstr = mw_bus(SRC_SPARE, DST_NONE, 1'b1, 1'b0, 4'b0000);   // NOP
        case (t_state)
            2'd0: uinstr = mw_bus(SRC_PO, DST_MI, 1'b0, 1'b0, 4'b0000); // PC -> MAR
            2'd1: uinstr = mw_bus(SRC_RO, DST_II, 1'b0, 1'b1, 4'b0000); // RAM -> IR, P+
            default: begin
                case (ir_op)
                    OP_LDX: uinstr = mw_bus(SRC_IOL, DST_XI, 1'b1, 1'b0, 4'b0000);
                    OP_LDY: uinstr = mw_bus(SRC_IOL, DST_YI, 1'b1, 1'b0, 4'b0000);
                    OP_ADD: uinstr = mw_alu(ALU_ADD, DST_XI);
                    OP_SUB: uinstr = mw_alu(ALU_SUB, DST_XI);
                    OP_AND: uinstr = mw_alu(ALU_AND, DST_XI);
                    OP_OR:  uinstr = mw_alu(ALU_OR, DST_XI);
                    // X sits on out_data, DO is the valid pulse
                    OP_OUT: uinstr = mw_bus(SRC_DO, DST_NONE, 1'b1, 1'b0, 4'b0000);
                    // Jump target from IR low byte, bits {JC JZ JGT JLT}
                    OP_JMP: uinstr = mw_bus(SRC_IOL, DST_NONE, 1'b1, 1'b0, 4'b1111);
                    OP_JZ:  uinstr = mw_bus(SRC_IOL, DST_NONE, 1'b1, 1'b0, 4'b0100);
                    OP_JC:  uinstr = mw_bus(SRC_IOL, DST_NONE, 1'b1, 1'b0, 4'b1000);
                    OP_JLT: uinstr = mw_bus(SRC_IOL, DST_NONE, 1'b1, 1'b0, 4'b0001);
                    OP_HLT: uinstr = mw_bus(SRC_SPARE, DST_HALT, 1'b1, 1'b0, 4'b0000);
                    default: ;                                          // NOP and unused
                endcase
            end
        endcase
    end

endmodule

// ==== source/ucode_decoder.sv ====
////////////////////////////////////////
// Expands one microinstruction into the
// bus, ALU and jump strobes
////////////////////////////////////////
`timescale 1ns/1ps

// Bit | Meaning
//  15 | EO, active low
//  14 | EO ? EX : src[2]
//  13 | EO ? NX : src[1]
//  12 | EO ? EY : src[0]
//  11 | EO ? NY : RT
//  10 | EO ? F  : P+
//   9 | EO ? NO : unused
// 8-6 | dst
// 5-2 | JC JZ JGT JLT
module ucode_decoder (
    input  cpu_pkg::uinstr_t uinstr,
    input  logic             active,     // Low in IDLE and HALTED
    ctrl_if.dec              ctl
);
    import cpu_pkg::*;

    logic     src_en;                    // ALU off, source field valid
    bus_src_e src;
    bus_dst_e dst;

    assign src_en = active & uinstr[15];
    assign src    = bus_src_e'(uinstr[14:12]);
    assign dst    = bus_dst_e'(uinstr[8:6]);

    // ALU drives the bus when EO is low
    assign ctl.alu_out = active & ~uinstr[15];
    assign ctl.alu_ctl = active ? uinstr[14:9] : 6'b000000; // Harmless when EO is off

    // Source decode, disabled while the ALU drives
    assign ctl.pc_out  = src_en && (src == SRC_PO);
    assign ctl.irh_out = src_en && (src == SRC_IOH);
    assign ctl.irl_out = src_en && (src == SRC_IOL);
    assign ctl.ram_out = src_en && (src == SRC_RO);
    assign ctl.x_out   = src_en && (src == SRC_XO);
    assign ctl.y_out   = src_en && (src == SRC_YO);
    assign ctl.dev_out = src_en && (src == SRC_DO);  // Also the output port strobe

    // RT and P+ share bits with NY and F
    assign ctl.rt     = src_en & uinstr[11];
    assign ctl.pc_inc = src_en & uinstr[10];

    // Destination decode, code 0 means nobody listens
    assign ctl.mar_in = active && (dst == DST_MI);
    assign ctl.ir_in  = active && (dst == DST_II);
    assign ctl.ram_in = active && (dst == DST_RI);
    assign ctl.x_in   = active && (dst == DST_XI);
    assign ctl.y_in   = active && (dst == DST_YI);
    assign ctl.dev_in = active && (dst == DST_DI);
    assign ctl.halt   = active && (dst == DST_HALT); // Spare code reused

    assign ctl.jc  = active & uinstr[5];
    assign ctl.jz  = active & uinstr[4];
    assign ctl.jgt = active & uinstr[3];
    assign ctl.jlt = active & uinstr[2];

endmodule

// ==== test/tb_cpu.sv ====
////////////////////////////////////////
// Random-program testbench for cpu_top
// checked against an instruction model
////////////////////////////////////////
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    localparam int ADDR_W  = 8;
    localparam int TIMEOUT = 500;           // Cycles allowed per program run

    logic clk, rst_n, load_en, run, out_valid, halted;
    logic [ADDR_W-1:0] load_addr;
    word_t load_data, out_data;

    logic [31:0] lfsr;
    word_t  prog[$];                        // Program image from address 0
    word_t  exp_q[$];                       // Expected OUT words
    word_t  mx, my;                         // Model X and Y carried across runs
    flags_t mflags;
    int     errors, checks, tests, test_err0;
    int     first_out;                      // Cycles from run to first out_valid

    cpu_top #(.ADDR_W(ADDR_W)) dut_i (
        .clk(clk), .rst_n(rst_n), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .run(run), .out_data(out_data),
        .out_valid(out_valid), .halted(halted)
    );

    always #10 clk = ~clk;

    // Galois LFSR stepped once per bit taken
    function automatic int unsigned rand_bits(int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = (v << 1) | {31'd0, lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t instr(opcode_e op, int arg);
        return {op, 4'h0, arg[7:0]};       // Operand in the low byte
    endfunction

    function automatic opcode_e alu_pick();
        opcode_e ops[4] = '{OP_ADD, OP_SUB, OP_AND, OP_OR};
        return ops[rand_bits(2)];
    endfunction

    function automatic opcode_e jump_pick();
        opcode_e ops[4] = '{OP_JZ, OP_JC, OP_JLT, OP_JMP};
        return ops[rand_bits(2)];
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s: got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERR t=%0t %s: got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // Instruction-level reference that walks prog until HLT
    task automatic model_run();
        int pc, steps;
        word_t w, r;
        logic [16:0] sum;
        logic is_alu;
        exp_q.delete();
        pc = 0;
        for (steps = 0; steps < 1000 && pc < prog.size(); steps++) begin
            w = prog[pc];
            pc++;
            is_alu = 1'b1;
            sum = '0;                       // No adder carry for AND and OR
            r = '0;
            case (opcode_e'(w[15:12]))
                OP_ADD: begin
                    sum = {1'b0, mx} + {1'b0, my};
                    r = sum[15:0];
                end
                OP_SUB: begin
                    sum = {1'b0, ~mx} + {1'b0, my};   // Carry of the inverted-X add
                    r = mx - my;
                end
                OP_AND: r = mx & my;
                OP_OR:  r = mx | my;
                default: is_alu = 1'b0;
            endcase
            if (is_alu) begin
                mx = r;
                mflags.c  = sum[16];
                mflags.z  = (r == 16'h0000);
                mflags.lt = r[15];
                mflags.gt = !mflags.z && !mflags.lt;
            end
            case (opcode_e'(w[15:12]))
                OP_LDX: mx = {8'h00, w[7:0]};
                OP_LDY: my = {8'h00, w[7:0]};
                OP_OUT: exp_q.push_back(mx);
                OP_JMP: pc = int'(w[7:0]);
                OP_JZ:  if (mflags.z) pc = int'(w[7:0]);
                OP_JC:  if (mflags.c) pc = int'(w[7:0]);
                OP_JLT: if (mflags.lt) pc = int'(w[7:0]);
                OP_HLT: break;
                default: ;
            endcase
        end
    endtask

    // Writes prog into RAM one word per cycle
    task automatic load_program(bit expect_quiet);
        for (int i = 0; i < prog.size(); i++) begin
            load_en   = 1'b1;
            load_addr = i[ADDR_W-1:0];
            load_data = prog[i];
            @(negedge clk);
            if (expect_quiet) begin
                check_bit("out_valid", out_valid, 1'b0);
                check_bit("halted", halted, 1'b0);
            end
            @(posedge clk);
            #2;
        end
        load_en = 1'b0;
    endtask

    // Loads prog, pulses run and compares every OUT until halted
    task automatic run_and_check();
        int n_out, cyc;
        bit done;
        model_run();
        load_program(1'b0);
        n_out = 0;
        done = 1'b0;
        first_out = -1;
        run = 1'b1;
        for (cyc = 0; cyc < TIMEOUT && !done; cyc++) begin
            @(negedge clk);
            if (out_valid) begin
                if (first_out < 0) first_out = cyc;
                if (n_out < exp_q.size()) check_word("out_data", out_data, exp_q[n_out]);
                else begin
                    errors++;
                    $display("t=%0t out_valid pulsed more often than the model expects", $time);
                end
                n_out++;
            end
            done = (cyc > 0) && halted;     // Cycle 0 may still show the old HALTED
            @(posedge clk);
            #2;
            run = 1'b0;
        end
        if (!done) begin
            errors++;
            $display("t=%0t halted did not rise within %0d cycles", $time, TIMEOUT);
        end
        check_count("out_count", n_out, exp_q.size());
        repeat (4) begin                    // Quiet after HLT
            @(negedge clk);
            check_bit("out_valid", out_valid, 1'b0);
            check_bit("halted", halted, 1'b1);
            @(posedge clk);
            #2;
        end
    endtask

    task automatic start_test();
        tests++;
        test_err0 = errors;
    endtask

    task automatic report_test(string name);
        $display("test %0d %s: %s (%0d errors)", tests, name,
                 (errors == test_err0) ? "ok" : "FAILED", errors - test_err0);
    endtask

    initial begin
        clk       = 0;
        rst_n     = 0;
        load_en   = 0;
        load_addr = '0;
        load_data = '0;
        run       = 0;
        lfsr      = 32'hd891dbd2;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        mx        = '0;                     // DUT reset values
        my        = '0;
        mflags    = '0;
        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;

        start_test();                       // Idle after reset and during a load without run
        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("halted", halted, 1'b0);
        @(posedge clk);
        #2;
        prog = '{instr(OP_LDX, rand_bits(8)), instr(OP_OUT, 0), instr(OP_HLT, 0)};
        load_program(1'b1);
        report_test("reset_idle");

        start_test();                       // LDX then OUT with the pulse on cycle 6
        run_and_check();
        check_count("first_out_cycle", first_out, 6);
        report_test("ldx_out_timing");

        start_test();
        for (int p = 0; p < 4; p++) begin
            prog.delete();
            for (int g = 0; g < 6; g++) begin
                if (rand_bits(2) != 0) prog.push_back(instr(OP_LDX, rand_bits(8)));
                prog.push_back(instr(OP_LDY, rand_bits(8)));
                prog.push_back(instr(alu_pick(), 0));
                prog.push_back(instr(OP_OUT, 0));
            end
            prog.push_back(instr(OP_HLT, 0));
            run_and_check();
        end
        report_test("alu_random");

        start_test();
        for (int p = 0; p < 4; p++) begin
            int unsigned ximm;
            prog.delete();
            for (int g = 0; g < 6; g++) begin
                ximm = rand_bits(8);
                prog.push_back(instr(OP_LDX, ximm));
                // Equal operands make the zero cases likely
                prog.push_back(instr(OP_LDY, (rand_bits(1) == 1) ? ximm : rand_bits(8)));
                prog.push_back(instr(alu_pick(), 0));
                prog.push_back(instr(jump_pick(), prog.size() + 2));
                prog.push_back(instr(OP_OUT, 0));   // Skipped when the jump is taken
                prog.push_back(instr(OP_OUT, 0));   // Jump target
            end
            prog.push_back(instr(OP_HLT, 0));
            run_and_check();
        end
        report_test("jumps");

        start_test();                       // OUTs after HLT must never show
        prog = '{instr(OP_LDX, rand_bits(8)), instr(OP_LDY, rand_bits(8)),
                 instr(OP_ADD, 0), instr(OP_OUT, 0), instr(OP_HLT, 0),
                 instr(OP_OUT, 0), instr(OP_OUT, 0)};
        run_and_check();
        report_test("halt");

        start_test();                       // Reload while halted with X and Y carried over
        prog = '{instr(OP_OUT, 0), instr(alu_pick(), 0), instr(OP_OUT, 0),
                 instr(alu_pick(), 0), instr(OP_OUT, 0), instr(OP_HLT, 0)};
        run_and_check();
        report_test("reload_carry");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
